// ==== common/dcache_settings.svh ====
`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

// Data word and address width
`define DCACHE_WORD_W 32

// Address split
// 26 tag bits, 3 index bits, 1 word offset bit, 2 byte bits
`define DCACHE_TAG_W 26
`define DCACHE_IDX_W 3

// Number of sets, two ways each
`define DCACHE_SETS 8

// Halt statistics go to this word address
// Holds served requests minus fills
`define DCACHE_COUNT_ADDR 32'h0000_3100

`endif

// ==== common/dcache_types_pkg.sv ====
`default_nettype none

`include "dcache_settings.svh"

// Storage and address types of the data cache
package dcache_types_pkg;

	// Byte bits below the word offset
	localparam int BYTE_W = `DCACHE_WORD_W - `DCACHE_TAG_W - `DCACHE_IDX_W - 1;

	// One data word or one address
	typedef logic [`DCACHE_WORD_W-1:0] word_t;

	// Tag and set index fields
	typedef logic [`DCACHE_TAG_W-1:0] tag_t;
	typedef logic [`DCACHE_IDX_W-1:0] idx_t;

	// Request address, MSB first
	typedef struct packed {
		tag_t              tag;
		idx_t              idx;
		logic              word_off;
		logic [BYTE_W-1:0] byte_off;
	} dcache_addr_t;

	// One block of the cache
	// Packed as {idx, way}, so slot number is idx*2 + way
	typedef struct packed {
		idx_t idx;
		logic way;
	} slot_t;

endpackage

`default_nettype wire

// ==== common/dcache_ctrl_pkg.sv ====
`default_nettype none

// Controller state and memory operation codes
package dcache_ctrl_pkg;

	// Controller states
	// *1 states move word 0, *2 states move word 1
	typedef enum logic [3:0] {
		IDLE,
		VICTIM_WB1,
		VICTIM_WB2,
		FETCH1,
		FETCH2,
		FLUSH_CHECK,
		FLUSH_WB1,
		FLUSH_WB2,
		WRITE_COUNT,
		FLUSHED
	} dcache_state_t;

	// Memory operation requested by the controller
	typedef enum logic [2:0] {
		MEM_NONE,
		MEM_VICTIM_WB,
		MEM_FETCH,
		MEM_DIRTY_WB,
		MEM_COUNT_WR
	} mem_op_t;

endpackage

`default_nettype wire

// ==== dcache_array/dcache_hit_check.sv ====
`default_nettype none
`timescale 1ns/100ps

// Address split, tag compare and load word select
// Purely combinational
module dcache_hit_check
	import dcache_types_pkg::*;
(
	input  word_t            mem_addr,
	// Both ways of the addressed set
	input  tag_t [1:0]       set_tags,
	input  logic [1:0]       set_valids,
	input  word_t [1:0][1:0] set_words,
	// Request fields
	output tag_t             tag,
	output idx_t             idx,
	output logic             word_off,
	// Hit result
	output logic             match,
	output logic             match_way,
	output word_t            load_word
);

	dcache_addr_t req;
	logic [1:0]   way_hit;

	// Byte bits are dropped, accesses are word aligned
	assign req      = dcache_addr_t'(mem_addr);
	assign tag      = req.tag;
	assign idx      = req.idx;
	assign word_off = req.word_off;

	// Per-way compare
	// A way only hits when it holds a valid block
	always_comb begin
		for (int w = 0; w < 2; w++) begin
			way_hit[w] = set_valids[w] && (set_tags[w] == req.tag);
		end
	end

	assign match = |way_hit;

	// Both ways never hold the same tag, so way 1 alone decides
	// No match falls back to way 0
	assign match_way = way_hit[1];

	// Word of the hit way, picked by the word offset
	assign load_word = set_words[match_way][req.word_off];

endmodule

`default_nettype wire

// ==== dcache_array/dcache_array.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "dcache_settings.svh"

// Tag, data and state storage of the cache
// Updates land one edge after their strobe
module dcache_array
	import dcache_types_pkg::*;
(
	input  logic             CLK,
	input  logic             nRST,
	// Request fields
	input  idx_t             idx,
	input  tag_t             tag,
	input  logic             word_off,
	input  logic             match_way,
	// Write hit
	input  logic             write_hit,
	input  word_t            store_data,
	// Fill from memory into the LRU way
	input  logic             fill_en,
	input  logic             word_sel,
	input  word_t            fill_data,
	// LRU update and flush cleaning
	input  logic             touch,
	input  logic             clean_en,
	// Set contents at idx
	output tag_t [1:0]       set_tags,
	output logic [1:0]       set_valids,
	output word_t [1:0][1:0] set_words,
	// Victim at idx
	output logic             lru_way,
	output logic             victim_dirty,
	output tag_t             victim_tag,
	// Dirty scan
	output logic             some_dirty,
	output slot_t            dirty_slot,
	output tag_t             slot_tag,
	output word_t [1:0]      slot_words
);

	localparam int SLOTS = 2 * `DCACHE_SETS;

	// Block payload, [way] and [way][word]
	tag_t [1:0]                   tags [`DCACHE_SETS];
	word_t [1:0][1:0]             data [`DCACHE_SETS];

	// Block state, [set][way]
	logic [`DCACHE_SETS-1:0][1:0] valid;
	logic [`DCACHE_SETS-1:0][1:0] dirty;

	// One bit per set, names the least recently used way
	logic [`DCACHE_SETS-1:0]      lru;

	// Dirty bits flattened, bit number equals slot number
	logic [SLOTS-1:0]             dirty_flat;

	//////////////////////////////////////////////////////////////////////
	// Payload writes
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK) begin
		// Store from the datapath into the hit way
		if (write_hit) begin
			data[idx][match_way][word_off] <= store_data;
		end
		// Memory word into the victim way
		// Tag goes in with the second word
		if (fill_en) begin
			data[idx][lru_way][word_sel] <= fill_data;
			if (word_sel) begin
				tags[idx][lru_way] <= tag;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Valid, dirty and LRU
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			valid <= '0;
			dirty <= '0;
			lru   <= '0;
		end else begin
			if (write_hit) begin
				dirty[idx][match_way] <= 1'b1;
			end
			// Block becomes usable only after both words are in
			if (fill_en && word_sel) begin
				valid[idx][lru_way] <= 1'b1;
				dirty[idx][lru_way] <= 1'b0;
			end
			// Other way becomes the next victim
			if (touch) begin
				lru[idx] <= ~match_way;
			end
			// Slot written back during flush
			if (clean_en) begin
				dirty[dirty_slot.idx][dirty_slot.way] <= 1'b0;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Read side
	//////////////////////////////////////////////////////////////////////

	assign set_tags   = tags[idx];
	assign set_valids = valid[idx];
	assign set_words  = data[idx];

	assign lru_way      = lru[idx];
	assign victim_dirty = dirty[idx][lru[idx]];
	assign victim_tag   = tags[idx][lru[idx]];

	// Dirty scan over all slots
	// Later slots win, so the highest dirty slot is reported
	assign dirty_flat = dirty;

	always_comb begin
		some_dirty = 1'b0;
		dirty_slot = '0;
		for (int s = 0; s < SLOTS; s++) begin
			if (dirty_flat[s]) begin
				some_dirty = 1'b1;
				dirty_slot = slot_t'(s[$bits(slot_t)-1:0]);
			end
		end
	end

	// Contents of the reported slot for write-back
	assign slot_tag   = tags[dirty_slot.idx][dirty_slot.way];
	assign slot_words = data[dirty_slot.idx][dirty_slot.way];

	// Controller only fills outside IDLE and only hits in IDLE
	assert property (@(posedge CLK) disable iff (!nRST) !(write_hit && fill_en))
		else $error("dcache_array: write hit and fill in the same cycle");

endmodule

`default_nettype wire

// ==== controller/dcache_controller.sv ====
`default_nettype none
`timescale 1ns/100ps

// Miss, fill, write-back and flush FSM with statistics counters
module dcache_controller
	import dcache_types_pkg::*;
	import dcache_ctrl_pkg::*;
(
	input  logic    CLK,
	input  logic    nRST,
	// Datapath request
	input  logic    halt,
	input  logic    mem_ren,
	input  logic    mem_wen,
	// From hit check and array
	input  logic    match,
	input  logic    lru_way,
	input  logic    victim_dirty,
	input  logic    some_dirty,
	// Memory wait level
	input  logic    dwait,
	// Datapath response
	output logic    dhit,
	output logic    flushed,
	// Array strobes
	output logic    write_hit,
	output logic    fill_en,
	output logic    touch,
	output logic    clean_en,
	// Memory port control
	output logic    word_sel,
	output mem_op_t mem_op,
	output word_t   count
);

	dcache_state_t state;
	dcache_state_t next_state;

	logic  req;
	logic  fill_done;
	word_t hit_count;
	word_t fill_count;

	assign req = mem_ren || mem_wen;

	// Hits are served only in IDLE, and halt takes over the cycle
	assign dhit      = (state == IDLE) && !halt && req && match;
	assign write_hit = dhit && mem_wen;
	assign touch     = dhit;

	// Each fill word lands when its memory access completes
	assign fill_en   = ((state == FETCH1) || (state == FETCH2)) && !dwait;
	assign fill_done = (state == FETCH2) && !dwait;

	// Slot is clean once its second word is in memory
	assign clean_en = (state == FLUSH_WB2) && !dwait;
	assign flushed  = (state == FLUSHED);

	//////////////////////////////////////////////////////////////////////
	// Next state
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		next_state = state;
		case (state)
			IDLE: begin
				if (halt) begin
					next_state = FLUSH_CHECK;
				end else if (req && !match) begin
					// Dirty victim goes out before the new block comes in
					next_state = victim_dirty ? VICTIM_WB1 : FETCH1;
				end
			end
			VICTIM_WB1:  if (!dwait) next_state = VICTIM_WB2;
			VICTIM_WB2:  if (!dwait) next_state = FETCH1;
			FETCH1:      if (!dwait) next_state = FETCH2;
			// Back to IDLE where the request now hits
			FETCH2:      if (!dwait) next_state = IDLE;
			FLUSH_CHECK: next_state = some_dirty ? FLUSH_WB1 : WRITE_COUNT;
			FLUSH_WB1:   if (!dwait) next_state = FLUSH_WB2;
			FLUSH_WB2:   if (!dwait) next_state = FLUSH_CHECK;
			WRITE_COUNT: if (!dwait) next_state = FLUSHED;
			// Held until reset
			FLUSHED:     next_state = FLUSHED;
			default:     next_state = IDLE;
		endcase
	end

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			state <= IDLE;
		end else begin
			state <= next_state;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Memory operation decode
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		mem_op   = MEM_NONE;
		word_sel = 1'b0;
		case (state)
			VICTIM_WB1:  mem_op = MEM_VICTIM_WB;
			VICTIM_WB2: begin
				mem_op   = MEM_VICTIM_WB;
				word_sel = 1'b1;
			end
			FETCH1:      mem_op = MEM_FETCH;
			FETCH2: begin
				mem_op   = MEM_FETCH;
				word_sel = 1'b1;
			end
			FLUSH_WB1:   mem_op = MEM_DIRTY_WB;
			FLUSH_WB2: begin
				mem_op   = MEM_DIRTY_WB;
				word_sel = 1'b1;
			end
			WRITE_COUNT: mem_op = MEM_COUNT_WR;
			default:     mem_op = MEM_NONE;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// Statistics
	//////////////////////////////////////////////////////////////////////

	// Every served request ends in a hit, misses included
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			hit_count  <= '0;
			fill_count <= '0;
		end else begin
			if (dhit) begin
				hit_count <= hit_count + 1'b1;
			end
			if (fill_done) begin
				fill_count <= fill_count + 1'b1;
			end
		end
	end

	assign count = hit_count - fill_count;

	// Once flushed the cache stays quiet on the memory bus
	assert property (@(posedge CLK) disable iff (!nRST)
		flushed |=> flushed && (mem_op == MEM_NONE))
		else $error("dcache_controller: memory access after flush");

	// Both fill words must land in the same way of the set
	assert property (@(posedge CLK) disable iff (!nRST)
		(state == FETCH1) |=> $stable(lru_way))
		else $error("dcache_controller: victim way moved during fill");

endmodule

`default_nettype wire

// ==== design/dcache_mem_port.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "dcache_settings.svh"

// Memory address, store data and read/write levels from the opcode
// Purely combinational
module dcache_mem_port
	import dcache_types_pkg::*;
	import dcache_ctrl_pkg::*;
(
	input  mem_op_t          mem_op,
	input  logic             word_sel,
	// Request block
	input  tag_t             tag,
	input  idx_t             idx,
	// Victim block at the request index
	input  tag_t             victim_tag,
	input  logic             lru_way,
	input  word_t [1:0][1:0] victim_words,
	// Block found by the dirty scan
	input  slot_t            dirty_slot,
	input  tag_t             slot_tag,
	input  word_t [1:0]      slot_words,
	// Statistics word and raw request address
	input  word_t            count,
	input  word_t            mem_addr,
	// Memory bus
	output logic             dren,
	output logic             dwen,
	output word_t            daddr,
	output word_t            dstore
);

	always_comb begin
		// Idle bus shows the request address with no level raised
		daddr  = mem_addr;
		dstore = '0;
		case (mem_op)
			MEM_VICTIM_WB: begin
				daddr  = {victim_tag, idx, word_sel, 2'b00};
				dstore = victim_words[lru_way][word_sel];
			end
			MEM_FETCH: begin
				daddr = {tag, idx, word_sel, 2'b00};
			end
			MEM_DIRTY_WB: begin
				daddr  = {slot_tag, dirty_slot.idx, word_sel, 2'b00};
				dstore = slot_words[word_sel];
			end
			MEM_COUNT_WR: begin
				daddr  = `DCACHE_COUNT_ADDR;
				dstore = count;
			end
			default: begin
				daddr  = mem_addr;
				dstore = '0;
			end
		endcase
	end

	// Read only for fetch, write for both write-backs and the count
	assign dren = (mem_op == MEM_FETCH);
	assign dwen = (mem_op == MEM_VICTIM_WB) || (mem_op == MEM_DIRTY_WB)
		|| (mem_op == MEM_COUNT_WR);

	// Single-port memory takes one direction at a time
	always_comb begin
		assert (!(dren && dwen))
			else $error("dcache_mem_port: read and write raised together");
	end

endmodule

`default_nettype wire

// ==== design/dcache_top.sv ====
`default_nettype none
`timescale 1ns/100ps

// 2-way set-associative write-back data cache
// Datapath on one side, single-port memory on the other
module dcache_top
	import dcache_types_pkg::*;
	import dcache_ctrl_pkg::*;
(
	input  logic  CLK,
	input  logic  nRST,
	// Datapath side
	input  logic  halt,
	input  logic  mem_ren,
	input  logic  mem_wen,
	input  word_t mem_addr,
	input  word_t mem_store,
	output logic  dhit,
	output word_t mem_load,
	output logic  flushed,
	// Memory side
	input  word_t dload,
	input  logic  dwait,
	output logic  dren,
	output logic  dwen,
	output word_t daddr,
	output word_t dstore
);

	// Request fields and hit result
	tag_t             req_tag;
	idx_t             req_idx;
	logic             word_off;
	logic             match;
	logic             match_way;

	// Set contents at the request index
	tag_t [1:0]       set_tags;
	logic [1:0]       set_valids;
	word_t [1:0][1:0] set_words;

	// Victim and flush scan
	logic             lru_way;
	logic             victim_dirty;
	tag_t             victim_tag;
	logic             some_dirty;
	slot_t            dirty_slot;
	tag_t             slot_tag;
	word_t [1:0]      slot_words;

	// Controller strobes
	logic             write_hit;
	logic             fill_en;
	logic             touch;
	logic             clean_en;
	logic             word_sel;
	mem_op_t          mem_op;
	word_t            count;

	//////////////////////////////////////////////////////////////////////
	// Input side: hit check and storage
	//////////////////////////////////////////////////////////////////////

	dcache_hit_check u_hit_check (
		.mem_addr   (mem_addr),
		.set_tags   (set_tags),
		.set_valids (set_valids),
		.set_words  (set_words),
		.tag        (req_tag),
		.idx        (req_idx),
		.word_off   (word_off),
		.match      (match),
		.match_way  (match_way),
		.load_word  (mem_load)
	);

	// Fill data comes straight off the memory bus
	dcache_array u_array (
		.CLK          (CLK),
		.nRST         (nRST),
		.idx          (req_idx),
		.tag          (req_tag),
		.word_off     (word_off),
		.match_way    (match_way),
		.write_hit    (write_hit),
		.store_data   (mem_store),
		.fill_en      (fill_en),
		.word_sel     (word_sel),
		.fill_data    (dload),
		.touch        (touch),
		.clean_en     (clean_en),
		.set_tags     (set_tags),
		.set_valids   (set_valids),
		.set_words    (set_words),
		.lru_way      (lru_way),
		.victim_dirty (victim_dirty),
		.victim_tag   (victim_tag),
		.some_dirty   (some_dirty),
		.dirty_slot   (dirty_slot),
		.slot_tag     (slot_tag),
		.slot_words   (slot_words)
	);

	//////////////////////////////////////////////////////////////////////
	// Processing: controller
	//////////////////////////////////////////////////////////////////////

	dcache_controller u_controller (
		.CLK          (CLK),
		.nRST         (nRST),
		.halt         (halt),
		.mem_ren      (mem_ren),
		.mem_wen      (mem_wen),
		.match        (match),
		.lru_way      (lru_way),
		.victim_dirty (victim_dirty),
		.some_dirty   (some_dirty),
		.dwait        (dwait),
		.dhit         (dhit),
		.flushed      (flushed),
		.write_hit    (write_hit),
		.fill_en      (fill_en),
		.touch        (touch),
		.clean_en     (clean_en),
		.word_sel     (word_sel),
		.mem_op       (mem_op),
		.count        (count)
	);

	//////////////////////////////////////////////////////////////////////
	// Output side: memory port
	//////////////////////////////////////////////////////////////////////

	// Victim words are both ways of the set, the port picks by LRU
	dcache_mem_port u_mem_port (
		.mem_op       (mem_op),
		.word_sel     (word_sel),
		.tag          (req_tag),
		.idx          (req_idx),
		.victim_tag   (victim_tag),
		.lru_way      (lru_way),
		.dirty_slot   (dirty_slot),
		.slot_tag     (slot_tag),
		.slot_words   (slot_words),
		.victim_words (set_words),
		.count        (count),
		.mem_addr     (mem_addr),
		.dren         (dren),
		.dwen         (dwen),
		.daddr        (daddr),
		.dstore       (dstore)
	);

endmodule

`default_nettype wire

// ==== bench/dcache_tb.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "dcache_settings.svh"

// Testbench for the 2-way write-back data cache
// Random requests against a reference model, memory with random wait
module dcache_tb
	import dcache_types_pkg::*;
();

	localparam int NUM_REQ   = 300;
	localparam int MEM_WORDS = 65536;
	// Four accesses of up to five cycles per request, then the flush of 16 blocks
	localparam int TIMEOUT_CYCLES = NUM_REQ * 4 * 5 + 16 * 10 + 2000;

	logic  CLK;
	logic  nRST;
	logic  halt;
	logic  mem_ren;
	logic  mem_wen;
	word_t mem_addr;
	word_t mem_store;
	logic  dhit;
	word_t mem_load;
	logic  flushed;
	word_t dload;
	logic  dwait;
	logic  dren;
	logic  dwen;
	word_t daddr;
	word_t dstore;

	integer seed;
	int     cycle_count = 0;
	int     req_num;

	// Memory model, word index from address bits 17:2
	word_t mem_img  [MEM_WORDS];
	// Last value written to each address, or the initial pattern
	word_t exp_data [MEM_WORDS];

	// Reference cache state, [set][way]
	logic  m_valid [`DCACHE_SETS][2];
	tag_t  m_tag   [`DCACHE_SETS][2];
	logic  m_dirty [`DCACHE_SETS][2];
	logic  m_lru   [`DCACHE_SETS];
	int    fills;

	// Request pool, three tags on two sets for conflicts
	tag_t  tag_pool [3];
	idx_t  idx_pool [2];

	// Predicted and observed memory accesses
	logic  exp_wr_q   [$];
	word_t exp_addr_q [$];
	word_t exp_data_q [$];
	logic  obs_wr_q   [$];
	word_t obs_addr_q [$];
	word_t obs_data_q [$];

	// Memory responder state
	logic  mem_busy;
	int    wait_left;

	dcache_top dcache_top_i (
		.CLK       (CLK),
		.nRST      (nRST),
		.halt      (halt),
		.mem_ren   (mem_ren),
		.mem_wen   (mem_wen),
		.mem_addr  (mem_addr),
		.mem_store (mem_store),
		.dhit      (dhit),
		.mem_load  (mem_load),
		.flushed   (flushed),
		.dload     (dload),
		.dwait     (dwait),
		.dren      (dren),
		.dwen      (dwen),
		.daddr     (daddr),
		.dstore    (dstore)
	);

	initial begin
		CLK = 1'b0;
		forever #4 CLK = ~CLK;
	end

	//////////////////////////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////////////////////////

	function automatic logic [15:0] mem_index(input word_t addr);
		return addr[17:2];
	endfunction

	// Every address bit shows up in the word
	function automatic word_t init_pattern(input word_t addr);
		return {addr[15:0], addr[31:16]} ^ 32'h5a5a_c3c3;
	endfunction

	task automatic stop_with_failure(input string what);
		$display("%s", what);
		$display("Simulation finished: FAIL");
		$fatal(1, "Run stopped at the first error");
	endtask

	task automatic expect_access(input logic wr, input word_t addr, input word_t data);
		exp_wr_q.push_back(wr);
		exp_addr_q.push_back(addr);
		exp_data_q.push_back(data);
	endtask

	task automatic check_quiet_outputs(input string when);
		assert (!dhit && !flushed && !dren && !dwen)
			else stop_with_failure($sformatf(
				"Fail outputs %s: dhit %h flushed %h dren %h dwen %h",
				when, dhit, flushed, dren, dwen));
	endtask

	//////////////////////////////////////////////////////////////////////
	// Reference cache
	//////////////////////////////////////////////////////////////////////

	// Updates the model for one request and predicts its memory traffic
	task automatic predict_request(input logic is_write, input word_t addr);
		tag_t  t;
		idx_t  i;
		logic  way;
		logic  hit;
		word_t vbase;
		word_t nbase;
		t     = addr[31:6];
		i     = addr[5:3];
		hit   = 1'b0;
		way   = m_lru[i];
		for (int w = 0; w < 2; w++) begin
			if (m_valid[i][w] && (m_tag[i][w] == t)) begin
				hit = 1'b1;
				way = (w == 1);
			end
		end
		if (!hit) begin
			fills++;
			// Dirty victim goes out first, two words at its own address
			if (m_valid[i][way] && m_dirty[i][way]) begin
				vbase = {m_tag[i][way], i, 3'b000};
				expect_access(1'b1, vbase, exp_data[mem_index(vbase)]);
				expect_access(1'b1, vbase | 32'h4, exp_data[mem_index(vbase | 32'h4)]);
			end
			nbase = {t, i, 3'b000};
			expect_access(1'b0, nbase, '0);
			expect_access(1'b0, nbase | 32'h4, '0);
			m_valid[i][way] = 1'b1;
			m_tag[i][way]   = t;
			m_dirty[i][way] = 1'b0;
		end
		if (is_write) begin
			m_dirty[i][way] = 1'b1;
		end
		m_lru[i] = ~way;
	endtask

	// Observed accesses of one request against the prediction
	task automatic compare_traffic();
		assert (obs_addr_q.size() == exp_addr_q.size())
			else stop_with_failure($sformatf(
				"Fail access count of request %0d: got %h expected %h",
				req_num, obs_addr_q.size(), exp_addr_q.size()));
		for (int k = 0; k < exp_addr_q.size(); k++) begin
			assert (obs_wr_q[k] == exp_wr_q[k])
				else stop_with_failure($sformatf("Fail dwen of access %0d: got %h expected %h",
					k, obs_wr_q[k], exp_wr_q[k]));
			assert (obs_addr_q[k] == exp_addr_q[k])
				else stop_with_failure($sformatf("Fail daddr of access %0d: got %h expected %h",
					k, obs_addr_q[k], exp_addr_q[k]));
			if (exp_wr_q[k]) begin
				assert (obs_data_q[k] == exp_data_q[k])
					else stop_with_failure($sformatf(
						"Fail dstore at %h: got %h expected %h",
						exp_addr_q[k], obs_data_q[k], exp_data_q[k]));
			end
		end
		exp_wr_q.delete();
		exp_addr_q.delete();
		exp_data_q.delete();
		obs_wr_q.delete();
		obs_addr_q.delete();
		obs_data_q.delete();
	endtask

	//////////////////////////////////////////////////////////////////////
	// Requests and flush
	//////////////////////////////////////////////////////////////////////

	task automatic run_request();
		word_t r;
		logic  is_write;
		word_t addr;
		word_t wdata;
		r        = $random(seed);
		is_write = r[0];
		addr     = {tag_pool[int'(r[15:8]) % 3], idx_pool[r[1]], r[2], 2'b00};
		wdata    = $random(seed);
		predict_request(is_write, addr);
		@(posedge CLK);
		mem_ren   <= !is_write;
		mem_wen   <= is_write;
		mem_addr  <= addr;
		mem_store <= wdata;
		// Request held until the cache answers
		do begin
			@(negedge CLK);
		end while (!dhit);
		if (!is_write) begin
			assert (mem_load == exp_data[mem_index(addr)])
				else stop_with_failure($sformatf("Fail mem_load at %h: got %h expected %h",
					addr, mem_load, exp_data[mem_index(addr)]));
		end
		compare_traffic();
		if (is_write) begin
			exp_data[mem_index(addr)] = wdata;
		end
	endtask

	task automatic check_flush();
		int    dirty_blocks;
		int    last;
		word_t a;
		dirty_blocks = 0;
		for (int s = 0; s < `DCACHE_SETS; s++) begin
			for (int w = 0; w < 2; w++) begin
				if (m_valid[s][w] && m_dirty[s][w]) begin
					dirty_blocks++;
				end
			end
		end
		// Two words per dirty block, then the statistics word
		assert (obs_addr_q.size() == 2 * dirty_blocks + 1)
			else stop_with_failure($sformatf("Fail flush access count: got %h expected %h",
				obs_addr_q.size(), 2 * dirty_blocks + 1));
		last = obs_addr_q.size() - 1;
		for (int k = 0; k < last; k++) begin
			assert (obs_wr_q[k])
				else stop_with_failure("The cache read from memory during the flush");
		end
		assert (obs_wr_q[last] && (obs_addr_q[last] == `DCACHE_COUNT_ADDR))
			else stop_with_failure($sformatf("Fail daddr of statistics write: got %h expected %h",
				obs_addr_q[last], `DCACHE_COUNT_ADDR));
		assert (obs_data_q[last] == word_t'(NUM_REQ - fills))
			else stop_with_failure($sformatf("Fail dstore of statistics word: got %h expected %h",
				obs_data_q[last], word_t'(NUM_REQ - fills)));
		// Every address of the pool holds its latest value
		for (int t = 0; t < 3; t++) begin
			for (int i = 0; i < 2; i++) begin
				for (int o = 0; o < 2; o++) begin
					a = {tag_pool[t], idx_pool[i], o[0], 2'b00};
					assert (mem_img[mem_index(a)] == exp_data[mem_index(a)])
						else stop_with_failure($sformatf(
							"Fail memory word at %h: got %h expected %h",
							a, mem_img[mem_index(a)], exp_data[mem_index(a)]));
				end
			end
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Memory responder
	//////////////////////////////////////////////////////////////////////

	// First cycle of an access latches the word, then 0 to 3 wait cycles
	always @(posedge CLK) begin
		if (!nRST) begin
			mem_busy  = 1'b0;
			wait_left = 0;
			dwait <= 1'b1;
			dload <= '0;
		end else if (dren || dwen) begin
			if (!mem_busy) begin
				mem_busy  = 1'b1;
				wait_left = $unsigned($random(seed)) % 4;
				dload <= mem_img[mem_index(daddr)];
				dwait <= (wait_left != 0);
			end else if (!dwait) begin
				// Access completes at this edge
				if (dwen) begin
					mem_img[mem_index(daddr)] = dstore;
				end
				obs_wr_q.push_back(dwen);
				obs_addr_q.push_back(daddr);
				obs_data_q.push_back(dwen ? dstore : dload);
				mem_busy = 1'b0;
				dwait <= 1'b1;
			end else begin
				wait_left--;
				dwait <= (wait_left != 0);
			end
		end
	end

	// Single-port memory, one direction at a time
	always @(negedge CLK) begin
		assert (!(dren && dwen))
			else stop_with_failure($sformatf("Fail dren %h and dwen %h high together",
				dren, dwen));
	end

	always @(posedge CLK) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			stop_with_failure("Timeout, the cache stopped answering");
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		nRST      = 1'b0;
		halt      = 1'b0;
		mem_ren   = 1'b0;
		mem_wen   = 1'b0;
		mem_addr  = '0;
		mem_store = '0;
		dload     = '0;
		dwait     = 1'b1;
		seed      = 26562;
		fills     = 0;
		tag_pool[0] = 26'h000_0011;
		tag_pool[1] = 26'h000_00a3;
		tag_pool[2] = 26'h000_02f5;
		idx_pool[0] = 3'd2;
		idx_pool[1] = 3'd5;
		for (int k = 0; k < MEM_WORDS; k++) begin
			mem_img[k]  = init_pattern({14'b0, k[15:0], 2'b00});
			exp_data[k] = mem_img[k];
		end
		for (int s = 0; s < `DCACHE_SETS; s++) begin
			m_lru[s] = 1'b0;
			for (int w = 0; w < 2; w++) begin
				m_valid[s][w] = 1'b0;
				m_dirty[s][w] = 1'b0;
				m_tag[s][w]   = '0;
			end
		end

		repeat (4) begin
			@(negedge CLK);
			check_quiet_outputs("during reset");
		end
		@(posedge CLK);
		nRST <= 1'b1;
		@(negedge CLK);
		check_quiet_outputs("after reset");

		for (req_num = 0; req_num < NUM_REQ; req_num++) begin
			run_request();
		end

		// Drop the request and halt
		@(posedge CLK);
		mem_ren <= 1'b0;
		mem_wen <= 1'b0;
		halt    <= 1'b1;
		do begin
			@(negedge CLK);
		end while (!flushed);
		check_flush();

		// Flushed holds and the bus stays quiet
		repeat (4) begin
			@(negedge CLK);
			assert (flushed && !dren && !dwen)
				else stop_with_failure($sformatf("Fail after flush: flushed %h dren %h dwen %h",
					flushed, dren, dwen));
		end

		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+common
common/dcache_types_pkg.sv
common/dcache_ctrl_pkg.sv
dcache_array/dcache_hit_check.sv
dcache_array/dcache_array.sv
controller/dcache_controller.sv
design/dcache_mem_port.sv
design/dcache_top.sv
bench/dcache_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= dcache_tb
RTL_TOP   ?= dcache_top
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Simulation finished: PASS

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o $(TOP)
	@out="$$(./$(BUILD_DIR)/$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
